//--- Bender.yml
package:
  name: fpcvt

# Headers fpcvt_macros.svh and tb_fpcvt_model.svh live in the package root
export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fpcvt_pkg.sv
      - count_leading_zeros.sv
      - float_converter.sv
      - float_rounder.sv
      - fpcvt_apb_regs.sv
      - fpcvt_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fpcvt.sv

//--- count_leading_zeros.sv
/*
 * Combinational leading-zero counter. When the operand is zero the count
 * output is 0 and is_all_zero_o is the only valid indication.
 */

`timescale 1ns/10ps

module count_leading_zeros #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         operand_i,
    output logic [$clog2(WIDTH)-1:0] lz_count_o,
    output logic                     is_all_zero_o
);

    localparam int CNT_W = $clog2(WIDTH);

    // Scan upward so that the highest set bit is the last one to assign
    // the count, which gives top-down priority
    always_comb begin
        lz_count_o = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (operand_i[i]) begin
                lz_count_o = CNT_W'(WIDTH - 1 - i);
            end
        end
    end

    assign is_all_zero_o = (operand_i == '0);

endmodule : count_leading_zeros

//--- float_converter.sv
/*
 * First pipeline stage. Float to integer truncates toward zero and saturates,
 * NaN gives all ones. Integer to float normalizes and leaves rounding to the
 * next stage. Denormal inputs are treated as zero.
 */

`timescale 1ns/10ps

`include "fpcvt_macros.svh"

module float_converter import fpcvt_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  cvt_req_t   req_i,
    output cvt_stage_t stage_o
);

    localparam logic signed [8:0] BIAS      = 9'(`FPCVT_BIAS);
    localparam logic [31:0]       MAX_INT32  = 32'h7FFF_FFFF;
    localparam logic [31:0]       MIN_INT32  = 32'h8000_0000;
    localparam logic [31:0]       MAX_UINT32 = 32'hFFFF_FFFF;

    // ========================================
    // Float to integer, before the register
    // ========================================

    float_t            f2i_in;
    logic              hidden_bit;
    logic              is_nan;
    logic signed [8:0] unbiased_exp;
    logic [54:0]       f2i_shifted;

    assign f2i_in     = req_i.operand.as_float;
    assign hidden_bit = (f2i_in.exponent != 8'd0);
    assign is_nan     = (f2i_in.exponent == 8'hFF) && (f2i_in.significand != '0);

    // Nine bits hold -127 up to 128, so an all-ones exponent stays positive
    // and saturates like any other large value
    assign unbiased_exp = $signed({1'b0, f2i_in.exponent}) - BIAS;

    // Only shifts of 0 to 31 matter, larger exponents saturate after the register
    assign f2i_shifted = {31'b0, hidden_bit, f2i_in.significand} << unbiased_exp[4:0];

    // ========================================
    // Integer to float, before the register
    // ========================================

    logic [31:0] i2f_in;
    logic        i2f_sign;
    logic [31:0] i2f_mag;
    logic [4:0]  i2f_lz;
    logic        i2f_zero;

    assign i2f_in   = req_i.operand.as_int;
    assign i2f_sign = req_i.is_signed & i2f_in[31];
    // The most negative signed value negates to itself, which is still its magnitude
    assign i2f_mag  = i2f_sign ? -i2f_in : i2f_in;

    count_leading_zeros #(
        .WIDTH (32)
    ) u_clz (
        .operand_i     (i2f_mag),
        .lz_count_o    (i2f_lz),
        .is_all_zero_o (i2f_zero)
    );

    // Stage register
    logic [31:0]       f2i_mag_q;
    logic signed [8:0] f2i_exp_q;
    logic              f2i_sign_q;
    logic              f2i_nan_q;
    logic              signed_q;
    conversion_type_t  op_q;
    logic [31:0]       i2f_mag_q;
    logic [4:0]        i2f_lz_q;
    logic              i2f_zero_q;
    logic              i2f_sign_q;
    logic              valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            f2i_mag_q  <= f2i_shifted[54:23];
            f2i_exp_q  <= unbiased_exp;
            f2i_sign_q <= f2i_in.sign;
            f2i_nan_q  <= is_nan;
            signed_q   <= req_i.is_signed;
            op_q       <= req_i.operation;
            i2f_mag_q  <= i2f_mag;
            i2f_lz_q   <= i2f_lz;
            i2f_zero_q <= i2f_zero;
            i2f_sign_q <= i2f_sign;
        end
    end

    // Saturation after the register
    logic [31:0] f2i_result;
    cvt_flags_t  f2i_flags;

    always_comb begin
        f2i_result = '0;
        f2i_flags  = '0;
        if (f2i_nan_q) begin
            f2i_result        = MAX_UINT32;
            f2i_flags.invalid = 1'b1;
        end else if (signed_q) begin
            // Magnitude of 2^31 or more does not fit a signed result
            if (f2i_exp_q >= 9'sd31) begin
                f2i_result          = f2i_sign_q ? MIN_INT32 : MAX_INT32;
                f2i_flags.underflow = f2i_sign_q;
                f2i_flags.overflow  = !f2i_sign_q;
            end else if (f2i_exp_q >= 9'sd0) begin
                f2i_result = f2i_sign_q ? -f2i_mag_q : f2i_mag_q;
            end
        end else begin
            // Negative values clamp to 0 and flag only past 2^32
            if (f2i_exp_q >= 9'sd32) begin
                f2i_result          = f2i_sign_q ? 32'd0 : MAX_UINT32;
                f2i_flags.underflow = f2i_sign_q;
                f2i_flags.overflow  = !f2i_sign_q;
            end else if (f2i_exp_q >= 9'sd0) begin
                f2i_result = f2i_sign_q ? 32'd0 : f2i_mag_q;
            end
        end
    end

    // Normalize so that the leading one lands on bit 31 and drops out as the hidden bit
    logic [31:0] i2f_norm;
    logic [7:0]  i2f_exp;
    float_t      i2f_float;
    round_bits_t i2f_round;

    assign i2f_norm = i2f_mag_q << i2f_lz_q;
    assign i2f_exp  = i2f_zero_q ? 8'd0 : (8'(`FPCVT_BIAS + 31) - {3'b0, i2f_lz_q});

    always_comb begin
        i2f_float.sign        = i2f_sign_q & !i2f_zero_q;
        i2f_float.exponent    = i2f_exp;
        i2f_float.significand = i2f_norm[30:8];
        i2f_round.guard       = i2f_norm[7];
        i2f_round.round       = i2f_norm[6];
        i2f_round.sticky      = |i2f_norm[5:0];
    end

    always_comb begin
        stage_o.valid     = valid_q;
        stage_o.operation = op_q;
        if (op_q == FLOAT2INT) begin
            stage_o.result     = f2i_result;
            stage_o.round_bits = '0;
            stage_o.flags      = f2i_flags;
        end else begin
            stage_o.result     = i2f_float;
            stage_o.round_bits = i2f_round;
            stage_o.flags      = '0;
        end
    end

    // The rounder and the register block both rely on a clean valid pulse
    a_stage_valid_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(stage_o.valid)
    ) else $error("Converter stage valid is unknown");

endmodule : float_converter

//--- float_rounder.sv
/*
 * Second pipeline stage. Only round to nearest, ties to even is supported.
 * Integer inputs never reach the top exponent, so the carry cannot overflow.
 */

`timescale 1ns/10ps

module float_rounder import fpcvt_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  cvt_stage_t stage_i,
    output cvt_rsp_t   rsp_o
);

    logic        round_up;
    logic [30:0] rounded_mag;
    logic [31:0] result;
    cvt_flags_t  flags;

    // Round up above the halfway point, or exactly at it when the LSB is odd
    assign round_up = stage_i.round_bits.guard &
                      (stage_i.round_bits.round | stage_i.round_bits.sticky |
                       stage_i.result[0]);

    // Exponent and significand are added as one field, so a significand
    // carry bumps the exponent
    assign rounded_mag = stage_i.result[30:0] + 31'(round_up);

    always_comb begin
        result = stage_i.result;
        flags  = stage_i.flags;
        if (stage_i.operation == INT2FLOAT) begin
            result        = {stage_i.result[31], rounded_mag};
            flags.inexact = |stage_i.round_bits;
        end
    end

    // Output register
    logic [31:0] result_q;
    cvt_flags_t  flags_q;
    logic        valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_i.valid) begin
            result_q <= result;
            flags_q  <= flags;
        end
    end

    assign rsp_o = '{result: result_q, flags: flags_q, valid: valid_q};

    // Truncating conversions are never reported as inexact
    a_no_inexact_f2i : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (stage_i.valid && stage_i.operation == FLOAT2INT) |=> !rsp_o.flags.inexact
    ) else $error("Inexact raised on a float to integer conversion");

endmodule : float_rounder

//--- fpcvt_apb_regs.sv
/*
 * APB slave with zero wait states. Only one conversion is in flight; a write
 * to OPERAND while busy returns pslverr and is dropped. Writes to RESULT and
 * STATUS are ignored without error.
 */

`timescale 1ns/10ps

`include "fpcvt_macros.svh"

module fpcvt_apb_regs import fpcvt_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`FPCVT_APB_AW-1:0] paddr_i,
    input  logic [31:0]              pwdata_i,
    output logic [31:0]              prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    output cvt_req_t                 req_o,
    input  cvt_rsp_t                 rsp_i
);

    logic             pslverr_q;
    logic             busy_q;
    logic             done_q;
    logic             launch_q;
    conversion_type_t ctrl_op_q;
    logic             ctrl_signed_q;
    logic [31:0]      operand_q;
    logic [31:0]      result_q;
    cvt_flags_t       flags_q;

    // ========================================
    // Access decode
    // ========================================

    logic setup_phase;
    logic access_phase;
    logic addr_mapped;
    logic operand_busy;
    logic launch;
    logic ctrl_wr;

    assign setup_phase  = psel_i & !penable_i;
    assign access_phase = psel_i & penable_i;

    assign addr_mapped = (paddr_i == `FPCVT_ADDR_CTRL)   ||
                         (paddr_i == `FPCVT_ADDR_OPERAND) ||
                         (paddr_i == `FPCVT_ADDR_RESULT)  ||
                         (paddr_i == `FPCVT_ADDR_STATUS);

    // A response arriving in the setup cycle frees the unit before the access edge
    assign operand_busy = pwrite_i & (paddr_i == `FPCVT_ADDR_OPERAND) &
                          busy_q & !rsp_i.valid;

    // The error flag registered in setup guards the write in the access phase
    assign launch  = access_phase & pwrite_i & (paddr_i == `FPCVT_ADDR_OPERAND) & !pslverr_q;
    assign ctrl_wr = access_phase & pwrite_i & (paddr_i == `FPCVT_ADDR_CTRL);

    // ========================================
    // Registers
    // ========================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pslverr_q     <= 1'b0;
            busy_q        <= 1'b0;
            done_q        <= 1'b0;
            launch_q      <= 1'b0;
            ctrl_op_q     <= INT2FLOAT;
            ctrl_signed_q <= 1'b0;
            result_q      <= '0;
            flags_q       <= '0;
        end else begin
            // Error is only ever visible during the access phase
            pslverr_q <= setup_phase & (!addr_mapped | operand_busy);
            launch_q  <= launch;
            if (ctrl_wr) begin
                ctrl_op_q     <= conversion_type_t'(pwdata_i[0]);
                ctrl_signed_q <= pwdata_i[1];
            end
            if (launch) begin
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
                flags_q <= '0;
            end else if (rsp_i.valid) begin
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
                result_q <= rsp_i.result;
                flags_q  <= rsp_i.flags;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin
            operand_q <= pwdata_i;
        end
    end

    // CTRL cannot change within one cycle of a launch, so it is read live here
    always_comb begin
        req_o.operand.as_int = operand_q;
        req_o.operation      = ctrl_op_q;
        req_o.is_signed      = ctrl_signed_q;
        req_o.valid          = launch_q;
    end

    // Read mux
    always_comb begin
        prdata_o = '0;
        if (access_phase && !pwrite_i) begin
            case (paddr_i)
                `FPCVT_ADDR_CTRL:    prdata_o = {30'b0, ctrl_signed_q, ctrl_op_q};
                `FPCVT_ADDR_OPERAND: prdata_o = operand_q;
                `FPCVT_ADDR_RESULT:  prdata_o = result_q;
                `FPCVT_ADDR_STATUS:  prdata_o = {26'b0, flags_q.inexact, flags_q.invalid,
                                                 flags_q.underflow, flags_q.overflow,
                                                 busy_q, done_q};
                default:             prdata_o = '0;
            endcase
        end
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = pslverr_q;

    // Responses only come back for a conversion that was launched
    a_rsp_while_busy : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) rsp_i.valid |-> busy_q
    ) else $error("Conversion response without a pending request");

    // The two pipeline stages return a response exactly three cycles after launch
    a_rsp_latency : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) launch |-> ##3 rsp_i.valid
    ) else $error("Conversion response missing three cycles after launch");

endmodule : fpcvt_apb_regs

//--- fpcvt_macros.svh
/*
 * Shared constants for the float conversion unit. Register addresses are byte
 * addresses on a 4-bit APB address bus; only word-aligned offsets are mapped.
 */

`ifndef FPCVT_MACROS_SVH
`define FPCVT_MACROS_SVH

// Exponent bias of IEEE-754 binary32
`define FPCVT_BIAS 127

// APB address width in bits
`define FPCVT_APB_AW 4

// ========================================
// Register map
// ========================================
`define FPCVT_ADDR_CTRL    4'h0
`define FPCVT_ADDR_OPERAND 4'h4
`define FPCVT_ADDR_RESULT  4'h8
`define FPCVT_ADDR_STATUS  4'hC

`endif

//--- fpcvt_pkg.sv
/*
 * Types shared by the conversion pipeline and the APB register block.
 * All valid bits are single-cycle pulses with no back-pressure.
 */

package fpcvt_pkg;

    // IEEE-754 binary32 word, sign in the top bit
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] significand;
    } float_t;

    // One operand word, read as a float or as an integer depending on direction
    typedef union packed {
        float_t      as_float;
        logic [31:0] as_int;
    } operand_u;

    typedef enum logic {
        INT2FLOAT = 1'b0,
        FLOAT2INT = 1'b1
    } conversion_type_t;

    // Bits shifted out below the significand LSB
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // Request from the register block into the converter
    typedef struct packed {
        operand_u         operand;
        conversion_type_t operation;
        logic             is_signed;
        logic             valid;
    } cvt_req_t;

    typedef struct packed {
        logic overflow;
        logic underflow;
        logic invalid;
        logic inexact;
    } cvt_flags_t;

    // Converter output, not yet rounded
    typedef struct packed {
        logic [31:0]      result;
        round_bits_t      round_bits;
        conversion_type_t operation;
        cvt_flags_t       flags;
        logic             valid;
    } cvt_stage_t;

    // Final response back to the register block
    typedef struct packed {
        logic [31:0] result;
        cvt_flags_t  flags;
        logic        valid;
    } cvt_rsp_t;

endpackage : fpcvt_pkg

//--- fpcvt_top.sv
/*
 * Float conversion unit behind an APB slave. Poll STATUS.done, which rises
 * three cycles after the OPERAND write that launched the conversion.
 */

`timescale 1ns/10ps

`include "fpcvt_macros.svh"

module fpcvt_top import fpcvt_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`FPCVT_APB_AW-1:0] paddr_i,
    input  logic [31:0]              pwdata_i,
    output logic [31:0]              prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o
);

    cvt_req_t   req;
    cvt_stage_t stage;
    cvt_rsp_t   rsp;

    // Register block launches requests and captures responses
    fpcvt_apb_regs u_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .req_o     (req),
        .rsp_i     (rsp)
    );

    float_converter u_converter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req),
        .stage_o (stage)
    );

    float_rounder u_rounder (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stage_i (stage),
        .rsp_o   (rsp)
    );

endmodule : fpcvt_top

//--- project.f
+incdir+.
fpcvt_pkg.sv
count_leading_zeros.sv
float_converter.sv
float_rounder.sv
fpcvt_apb_regs.sv
fpcvt_top.sv
tb_fpcvt.sv

//--- tb_fpcvt_model.svh
/*
 * Reference conversions for the testbench, included inside the testbench module.
 * Each function returns {flags, result} with flags in STATUS order, which is
 * {inexact, invalid, underflow, overflow}.
 */

`ifndef TB_FPCVT_MODEL_SVH
`define TB_FPCVT_MODEL_SVH

`include "fpcvt_macros.svh"

// Float to integer, truncating toward zero and saturating on overflow
function automatic logic [35:0] float_to_int_ref(input logic [31:0] bits,
                                                 input logic is_signed);
    logic        sign;
    logic [7:0]  exp_field;
    logic [22:0] frac;
    int          e;
    logic [63:0] mag;
    logic [31:0] res;
    logic [3:0]  flags;
    sign      = bits[31];
    exp_field = bits[30:23];
    frac      = bits[22:0];
    res       = '0;
    flags     = '0;
    if (exp_field == 8'hFF && frac != '0) begin
        // NaN
        res      = 32'hFFFF_FFFF;
        flags[2] = 1'b1;
    end else if (exp_field != 8'h00) begin
        // Zero and denormals fall through with a result of 0
        e = int'(exp_field) - `FPCVT_BIAS;
        if (e < 0) begin
            mag = '0;
        end else if (e > 40) begin
            mag = {64{1'b1}};
        end else begin
            mag = ({40'b0, 1'b1, frac} << e) >> 23;
        end
        if (is_signed) begin
            if (mag >= 64'h8000_0000) begin
                res      = sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
                flags[1] = sign;
                flags[0] = !sign;
            end else begin
                res = sign ? -mag[31:0] : mag[31:0];
            end
        end else begin
            if (mag >= 64'h1_0000_0000) begin
                res      = sign ? 32'h0 : 32'hFFFF_FFFF;
                flags[1] = sign;
                flags[0] = !sign;
            end else begin
                res = sign ? 32'h0 : mag[31:0];
            end
        end
    end
    return {flags, res};
endfunction

// Integer to float with round to nearest, ties to even
function automatic logic [35:0] int_to_float_ref(input logic [31:0] value,
                                                 input logic is_signed);
    logic        sign;
    logic [31:0] abs_val;
    int          msb;
    int          shift;
    logic [63:0] kept;
    logic [63:0] rem;
    logic [63:0] half;
    logic [7:0]  exp_field;
    logic        inexact;
    sign    = is_signed && value[31];
    abs_val = sign ? (~value + 32'd1) : value;
    inexact = 1'b0;
    if (abs_val == '0) begin
        return 36'h0;
    end
    msb = 0;
    for (int i = 0; i < 32; i++) begin
        if (abs_val[i]) begin
            msb = i;
        end
    end
    exp_field = 8'(`FPCVT_BIAS + msb);
    if (msb <= 23) begin
        kept = {32'b0, abs_val} << (23 - msb);
    end else begin
        // Split into the kept 24 bits and the remainder below them
        shift   = msb - 23;
        kept    = {32'b0, abs_val} >> shift;
        rem     = {32'b0, abs_val} & ((64'd1 << shift) - 64'd1);
        half    = 64'd1 << (shift - 1);
        inexact = (rem != '0);
        if (rem > half || (rem == half && kept[0])) begin
            kept = kept + 64'd1;
        end
        // Rounding up past 24 bits moves the leading one up a place
        if (kept == 64'h100_0000) begin
            kept      = kept >> 1;
            exp_field = exp_field + 8'd1;
        end
    end
    return {inexact, 3'b000, sign, exp_field, kept[22:0]};
endfunction

`endif

//--- tb_fpcvt.sv
/*
 * Testbench for the APB float conversion unit. Random operands come from a
 * fixed seed and are checked against the reference functions in the model.
 */

`timescale 1ns/10ps

`include "fpcvt_macros.svh"

module tb_fpcvt import fpcvt_pkg::*; ();

    localparam time         CLK_PERIOD  = 40ns;
    localparam time         DRIVE_DELAY = 2ns;
    localparam logic [31:0] RNG_SEED    = 32'h0407_39e5;
    localparam int          N_RAND_INT  = 300;
    localparam int          N_RAND_FLT  = 300;
    localparam int          N_SPECIAL   = 14;
    localparam int          MAX_POLLS   = 16;
    // Random runs, both sign modes of each special, and the directed tests
    localparam int NUM_TESTS     = N_RAND_INT + N_RAND_FLT + 2 * N_SPECIAL + 6 + 12;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 20 + 200;

    logic        clk_i;
    logic        rst_n_i;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    int          error_count;

    `include "tb_fpcvt_model.svh"

    fpcvt_top u_fpcvt_top (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s expected %h got %h", name, expected, actual);
        end
    endtask

    // ========================================
    // APB access tasks
    // ========================================

    // Called 2 ns after a rising edge, returns at the same point of a later cycle
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             input logic expect_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_i);
        #(DRIVE_DELAY);
        penable = 1'b1;
        // Mid access phase, so pslverr is settled
        @(negedge clk_i);
        check_value("pslverr", 32'(expect_err), 32'(pslverr));
        @(posedge clk_i);
        #(DRIVE_DELAY);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            input logic expect_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk_i);
        #(DRIVE_DELAY);
        penable = 1'b1;
        @(negedge clk_i);
        check_value("pslverr", 32'(expect_err), 32'(pslverr));
        check_value("pready", 32'h1, 32'(pready));
        data = prdata;
        @(posedge clk_i);
        #(DRIVE_DELAY);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls = 0;
        read_reg(`FPCVT_ADDR_STATUS, status, 1'b0);
        while (!status[0] && polls < MAX_POLLS) begin
            read_reg(`FPCVT_ADDR_STATUS, status, 1'b0);
            polls++;
        end
        if (!status[0]) begin
            error_count++;
            $display("Conversion never reported done after %0d status reads", MAX_POLLS);
        end
    endtask

    // One full conversion, checked for status, flags and result
    task automatic convert_and_check(input logic op, input logic is_signed,
                                     input logic [31:0] operand);
        logic [35:0] expected;
        logic [31:0] status;
        logic [31:0] result;
        if (op == FLOAT2INT) begin
            expected = float_to_int_ref(operand, is_signed);
        end else begin
            expected = int_to_float_ref(operand, is_signed);
        end
        write_reg(`FPCVT_ADDR_CTRL, {30'b0, is_signed, op}, 1'b0);
        write_reg(`FPCVT_ADDR_OPERAND, operand, 1'b0);
        // One cycle after launch: busy, done cleared, old flags cleared
        read_reg(`FPCVT_ADDR_STATUS, status, 1'b0);
        check_value("status_after_launch", 32'h2, status);
        wait_done(status);
        check_value("status", {26'b0, expected[35:32], 2'b01}, status);
        read_reg(`FPCVT_ADDR_RESULT, result, 1'b0);
        check_value("result", expected[31:0], result);
    endtask

    // Zeros, denormals, infinities, NaNs and values around the saturation limits
    function automatic logic [31:0] special_float(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'h0000_0001;
            3:       return 32'h807F_FFFF;
            4:       return 32'h7F80_0000;
            5:       return 32'hFF80_0000;
            6:       return 32'h7FC0_0000;
            7:       return 32'hFFFF_FFFF;
            8:       return 32'h4F00_0000;
            9:       return 32'hCF00_0000;
            10:      return 32'h4F80_0000;
            11:      return 32'hCF80_0000;
            12:      return 32'h3F7F_FFFF;
            default: return 32'hBF80_0000;
        endcase
    endfunction

    // ========================================
    // Watchdog
    // ========================================

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] value;
        logic [31:0] data;
        logic [7:0]  exp_field;
        logic [35:0] expected;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        error_count = 0;
        void'($urandom(RNG_SEED));

        repeat (2) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_n_i = 1'b1;

        // Everything reads back as zero out of reset
        read_reg(`FPCVT_ADDR_STATUS, data, 1'b0);
        check_value("status_reset", 32'h0, data);
        read_reg(`FPCVT_ADDR_RESULT, data, 1'b0);
        check_value("result_reset", 32'h0, data);

        // CTRL holds only its two low bits
        write_reg(`FPCVT_ADDR_CTRL, 32'h3, 1'b0);
        read_reg(`FPCVT_ADDR_CTRL, data, 1'b0);
        check_value("ctrl", 32'h3, data);
        write_reg(`FPCVT_ADDR_CTRL, 32'hFFFF_FFFE, 1'b0);
        read_reg(`FPCVT_ADDR_CTRL, data, 1'b0);
        check_value("ctrl", 32'h2, data);

        // ========================================
        // Integer to float
        // ========================================
        convert_and_check(INT2FLOAT, 1'b0, 32'h0);
        convert_and_check(INT2FLOAT, 1'b1, 32'h0);
        convert_and_check(INT2FLOAT, 1'b0, 32'hFFFF_FFFF);
        convert_and_check(INT2FLOAT, 1'b1, 32'hFFFF_FFFF);
        convert_and_check(INT2FLOAT, 1'b0, 32'h8000_0000);
        convert_and_check(INT2FLOAT, 1'b1, 32'h8000_0000);
        for (int i = 0; i < N_RAND_INT; i++) begin
            value = $urandom;
            // Half the values are shortened so small magnitudes get exercised too
            if ($urandom % 2) begin
                value = value >> ($urandom % 32);
            end
            convert_and_check(INT2FLOAT, 1'($urandom), value);
        end

        // ========================================
        // Float to integer
        // ========================================
        for (int i = 0; i < N_SPECIAL; i++) begin
            convert_and_check(FLOAT2INT, 1'b0, special_float(i));
            convert_and_check(FLOAT2INT, 1'b1, special_float(i));
        end
        for (int i = 0; i < N_RAND_FLT; i++) begin
            // Most exponents sit near the 32-bit saturation boundary
            if ($urandom % 4 != 0) begin
                exp_field = 8'(120 + $urandom % 41);
            end else begin
                exp_field = 8'($urandom);
            end
            value = {1'($urandom), exp_field, 23'($urandom)};
            convert_and_check(FLOAT2INT, 1'($urandom), value);
        end

        // A second OPERAND write right after launch is refused
        write_reg(`FPCVT_ADDR_CTRL, 32'h0, 1'b0);
        write_reg(`FPCVT_ADDR_OPERAND, 32'h1234_5679, 1'b0);
        write_reg(`FPCVT_ADDR_OPERAND, 32'h0000_0001, 1'b1);
        wait_done(data);
        expected = int_to_float_ref(32'h1234_5679, 1'b0);
        check_value("status", {26'b0, expected[35:32], 2'b01}, data);
        read_reg(`FPCVT_ADDR_RESULT, data, 1'b0);
        check_value("result", expected[31:0], data);

        // Unmapped addresses
        write_reg(4'h2, 32'hA5A5_A5A5, 1'b1);
        read_reg(4'h6, data, 1'b1);

        // Overflow flags from one run must not survive into the next
        convert_and_check(FLOAT2INT, 1'b1, 32'h7F80_0000);
        convert_and_check(INT2FLOAT, 1'b0, 32'd5);

        // Writing RESULT is silently ignored
        write_reg(`FPCVT_ADDR_RESULT, 32'hDEAD_BEEF, 1'b0);
        read_reg(`FPCVT_ADDR_RESULT, data, 1'b0);
        expected = int_to_float_ref(32'd5, 1'b0);
        check_value("result_after_write", expected[31:0], data);

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_fpcvt
